//--- minimig_mem_pkg.sv
// shared widths, RAM depth and sequencer states for the chip memory slice
// one word-wide RAM of RAM_WORDS words, addressed in 16-bit words
// byte enables are active high, bit 1 selects the upper byte
// every RTL file refers to these through package scoped names

package minimig_mem_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W    = 12;   // word address bits
  localparam int DATA_W    = 16;   // data word bits
  localparam int RAM_WORDS = 4096; // depth, 2**ADDR_W

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t; // word address
  typedef logic [DATA_W-1:0] word_t; // data word
  typedef logic [1:0]        be_t;   // {upper, lower} byte enable

  ////////////////////////////////////////////////////////////
  // sequencer states
  ////////////////////////////////////////////////////////////

  // one slot = idle (grant), access (ram enable), capture (done)
  typedef enum logic [1:0] {
    seq_idle    = 2'd0, // waiting for a slot start
    seq_access  = 2'd1, // ram cycle in flight
    seq_capture = 2'd2  // port latches read word
  } seq_state_t;

endpackage

//--- slot_timer.sv
// bus-cycle timer for the clk_28 domain
// the 7 MHz bus clock exists only as a slot start strobe, one every 4 clocks
// slot owner alternates: chip slot, then cpu slot, period 8 clocks
// count resets to 2 so the first slot start lands 2 clocks after lock

module slot_timer (
  input  logic clk_28,     // 28 MHz system clock
  input  logic pll_locked, // async reset, active low
  output logic slot_start, // one-cycle pulse at each bus cycle start
  output logic cpu_slot    // 1 = slot belongs to the cpu port
);

  ////////////////////////////////////////////////////////////
  // bus cycle counter
  ////////////////////////////////////////////////////////////

  logic [2:0] slot_cnt; // [1:0] phase in slot, [2] owner

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      slot_cnt <= 3'd2; // same start phase as the 7 MHz divider
    end else begin
      slot_cnt <= slot_cnt + 3'd1; // free running, wraps every 8
    end
  end

  ////////////////////////////////////////////////////////////
  // decodes
  ////////////////////////////////////////////////////////////

  assign slot_start = (slot_cnt[1:0] == 2'd0); // phase 0 of each slot
  assign cpu_slot   = slot_cnt[2];             // odd slots are cpu slots

endmodule

//--- ram_sequencer.sv
// slot arbiter and access sequencer for the shared RAM
// grants on slot start only, one access in flight at a time
// a slot's owner wins if pending; the cpu may borrow an idle chip slot,
// the chip never borrows a cpu slot
// grant is combinational in the slot start cycle t; en at t+1, done at t+2
// a slot is 4 clocks, so the sequencer is always idle again before the next one

module ram_sequencer (
  input  logic clk_28,       // 28 MHz system clock
  input  logic pll_locked,   // async reset, active low
  input  logic slot_start,   // bus cycle start strobe
  input  logic cpu_slot,     // current slot owner, 1 = cpu
  input  logic chip_pending, // chip port has a request waiting
  input  logic cpu_pending,  // cpu port has a request waiting
  output logic chip_grant,   // chip request taken this cycle
  output logic cpu_grant,    // cpu request taken this cycle
  output logic chip_done,    // chip read word ready to latch
  output logic cpu_done,     // cpu read word ready to latch
  output logic sel,          // ram mux select, 1 = cpu
  output logic en            // ram access strobe
);

  ////////////////////////////////////////////////////////////
  // slot selection
  ////////////////////////////////////////////////////////////

  minimig_mem_pkg::seq_state_t state; // sequencer state

  logic pick_chip; // chip owns slot and wants it
  logic pick_cpu;  // cpu owns slot, or borrows an idle chip slot
  logic start;     // an access begins this cycle

  assign pick_chip = !cpu_slot && chip_pending;
  assign pick_cpu  = cpu_slot ? cpu_pending
                              : (!chip_pending && cpu_pending); // borrow idle chip slot

  assign start = slot_start && (state == minimig_mem_pkg::seq_idle) &&
                 (pick_chip || pick_cpu);

  assign chip_grant = start && pick_chip; // exclusive with cpu_grant
  assign cpu_grant  = start && pick_cpu;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      state <= minimig_mem_pkg::seq_idle;
      sel   <= 1'b0; // chip by default
    end else begin
      case (state)
        minimig_mem_pkg::seq_idle: begin
          if (start) begin
            state <= minimig_mem_pkg::seq_access;
            sel   <= pick_cpu; // held through access and capture
          end
        end
        minimig_mem_pkg::seq_access: begin
          state <= minimig_mem_pkg::seq_capture; // ram registers the word now
        end
        minimig_mem_pkg::seq_capture: begin
          state <= minimig_mem_pkg::seq_idle; // port latches, ack next cycle
        end
        default: begin
          state <= minimig_mem_pkg::seq_idle; // unused encoding
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // strobes
  ////////////////////////////////////////////////////////////

  assign en        = (state == minimig_mem_pkg::seq_access);
  assign chip_done = (state == minimig_mem_pkg::seq_capture) && !sel;
  assign cpu_done  = (state == minimig_mem_pkg::seq_capture) &&  sel;

endmodule

//--- bus_port.sv
// four-phase req/ack endpoint, one per requester
// the requester holds we, addr, wdata and be until ack; these go to the RAM
// directly, so the port only tracks handshake state and the read word
// ack rises the cycle after done and falls the cycle after req is seen low
// rdata keeps its old value across writes

module bus_port (
  input  logic                      clk_28,     // 28 MHz system clock
  input  logic                      pll_locked, // async reset, active low
  input  logic                      req,        // requester strobe
  input  logic                      grant,      // sequencer took the request
  input  logic                      done,       // access complete, rd_word valid
  input  minimig_mem_pkg::word_t    rd_word,    // ram read register
  input  logic                      we,         // 1 = write access
  output logic                      pending,    // waiting for a slot
  output logic                      ack,        // handshake acknowledge
  output minimig_mem_pkg::word_t    rdata       // read data to requester
);

  ////////////////////////////////////////////////////////////
  // handshake state
  ////////////////////////////////////////////////////////////

  logic busy; // granted, done not yet seen

  // a request waits only while nothing is in flight and ack is low,
  // so a req held high after ack never raises a second access
  assign pending = req && !ack && !busy;

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      busy <= 1'b0;
      ack  <= 1'b0;
    end else begin
      if (grant) begin
        busy <= 1'b1; // access in flight
      end else if (done) begin
        busy <= 1'b0;
      end
      if (done) begin
        ack <= 1'b1; // completion to requester
      end else if (!req) begin
        ack <= 1'b0; // return to zero phase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (done && !we) begin
      rdata <= rd_word; // valid from ack rise until next read
    end
  end

endmodule

//--- ram_array.sv
// single-port word RAM shared by the chip and cpu ports
// request fields come straight from the top inputs, held under the handshake
// a write merges only the enabled bytes; a read registers the word
// rd_word is valid the cycle after en; contents have no reset

module ram_array (
  input  logic                      clk_28,     // 28 MHz system clock
  input  logic                      en,         // access strobe
  input  logic                      sel,        // 1 = cpu request
  input  logic                      chip_we,    // chip write
  input  minimig_mem_pkg::addr_t    chip_addr,  // chip word address
  input  minimig_mem_pkg::word_t    chip_wdata, // chip write data
  input  minimig_mem_pkg::be_t      chip_be,    // chip byte enables
  input  logic                      cpu_we,     // cpu write
  input  minimig_mem_pkg::addr_t    cpu_addr,   // cpu word address
  input  minimig_mem_pkg::word_t    cpu_wdata,  // cpu write data
  input  minimig_mem_pkg::be_t      cpu_be,     // cpu byte enables
  output minimig_mem_pkg::word_t    rd_word     // registered read word
);

  ////////////////////////////////////////////////////////////
  // request mux
  ////////////////////////////////////////////////////////////

  minimig_mem_pkg::word_t mem [minimig_mem_pkg::RAM_WORDS]; // storage

  logic                   we;    // selected write flag
  minimig_mem_pkg::addr_t addr;  // selected address
  minimig_mem_pkg::word_t wdata; // selected write word
  minimig_mem_pkg::be_t   be;    // selected byte enables

  assign we    = sel ? cpu_we    : chip_we;
  assign addr  = sel ? cpu_addr  : chip_addr;
  assign wdata = sel ? cpu_wdata : chip_wdata;
  assign be    = sel ? cpu_be    : chip_be;

  ////////////////////////////////////////////////////////////
  // ram access
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (en) begin
      if (we) begin
        if (be[0]) mem[addr][7:0]  <= wdata[7:0];  // lower byte
        if (be[1]) mem[addr][15:8] <= wdata[15:8]; // upper byte
      end else begin
        rd_word <= mem[addr]; // rd_word holds across writes
      end
    end
  end

endmodule

//--- minimig_mem_top.sv
// chip memory slice: chip and cpu requesters sharing one RAM on clk_28
// chip port owns even bus slots, cpu owns odd ones and may borrow idle chip slots
// each port is a four-phase req/ack handshake with 16-bit words and 2 byte enables
// chip ack follows chip req within 12 clocks; cpu latency depends on chip load
// pll_locked low clears handshake state but leaves RAM contents intact

module minimig_mem_top (
  input  logic                      clk_28,     // 28 MHz system clock
  input  logic                      pll_locked, // async reset, active low
  // chip port
  input  logic                      chip_req,   // chip request
  input  logic                      chip_we,    // chip write
  input  minimig_mem_pkg::addr_t    chip_addr,  // chip word address
  input  minimig_mem_pkg::word_t    chip_wdata, // chip write data
  input  minimig_mem_pkg::be_t      chip_be,    // chip byte enables
  output logic                      chip_ack,   // chip acknowledge
  output minimig_mem_pkg::word_t    chip_rdata, // chip read data
  // cpu port
  input  logic                      cpu_req,    // cpu request
  input  logic                      cpu_we,     // cpu write
  input  minimig_mem_pkg::addr_t    cpu_addr,   // cpu word address
  input  minimig_mem_pkg::word_t    cpu_wdata,  // cpu write data
  input  minimig_mem_pkg::be_t      cpu_be,     // cpu byte enables
  output logic                      cpu_ack,    // cpu acknowledge
  output minimig_mem_pkg::word_t    cpu_rdata   // cpu read data
);

  ////////////////////////////////////////////////////////////
  // internal signals
  ////////////////////////////////////////////////////////////

  logic                   slot_start;   // bus cycle start
  logic                   cpu_slot;     // slot owner
  logic                   chip_pending; // chip waiting
  logic                   cpu_pending;  // cpu waiting
  logic                   chip_grant;   // chip access starts
  logic                   cpu_grant;    // cpu access starts
  logic                   chip_done;    // chip access complete
  logic                   cpu_done;     // cpu access complete
  logic                   sel;          // ram mux select
  logic                   en;           // ram strobe
  minimig_mem_pkg::word_t rd_word;      // ram read register

  ////////////////////////////////////////////////////////////
  // slot timing and arbitration
  ////////////////////////////////////////////////////////////

  slot_timer slot_timer (
    .clk_28       (clk_28      ),
    .pll_locked   (pll_locked  ),
    .slot_start   (slot_start  ),
    .cpu_slot     (cpu_slot    )
  );

  ram_sequencer ram_sequencer (
    .clk_28       (clk_28      ),
    .pll_locked   (pll_locked  ),
    .slot_start   (slot_start  ),
    .cpu_slot     (cpu_slot    ),
    .chip_pending (chip_pending),
    .cpu_pending  (cpu_pending ),
    .chip_grant   (chip_grant  ),
    .cpu_grant    (cpu_grant   ),
    .chip_done    (chip_done   ),
    .cpu_done     (cpu_done    ),
    .sel          (sel         ),
    .en           (en          )
  );

  ////////////////////////////////////////////////////////////
  // requester endpoints
  ////////////////////////////////////////////////////////////

  bus_port chip_port (
    .clk_28       (clk_28      ),
    .pll_locked   (pll_locked  ),
    .req          (chip_req    ),
    .grant        (chip_grant  ),
    .done         (chip_done   ),
    .rd_word      (rd_word     ),
    .we           (chip_we     ),
    .pending      (chip_pending),
    .ack          (chip_ack    ),
    .rdata        (chip_rdata  )
  );

  bus_port cpu_port (
    .clk_28       (clk_28      ),
    .pll_locked   (pll_locked  ),
    .req          (cpu_req     ),
    .grant        (cpu_grant   ),
    .done         (cpu_done    ),
    .rd_word      (rd_word     ),
    .we           (cpu_we      ),
    .pending      (cpu_pending ),
    .ack          (cpu_ack     ),
    .rdata        (cpu_rdata   )
  );

  ////////////////////////////////////////////////////////////
  // shared ram
  ////////////////////////////////////////////////////////////

  ram_array ram_array (
    .clk_28       (clk_28      ),
    .en           (en          ),
    .sel          (sel         ),
    .chip_we      (chip_we     ),
    .chip_addr    (chip_addr   ),
    .chip_wdata   (chip_wdata  ),
    .chip_be      (chip_be     ),
    .cpu_we       (cpu_we      ),
    .cpu_addr     (cpu_addr    ),
    .cpu_wdata    (cpu_wdata   ),
    .cpu_be       (cpu_be      ),
    .rd_word      (rd_word     )
  );

endmodule

//--- mem_checker.sv
// handshake and arbitration assertions, bound into the memory top level
// everything is sampled on the rising clk_28 edge and ignored while pll_locked is low
// chip wait counter assumes req stays high until ack, as the handshake requires

module mem_checker (
  input logic                        clk_28,     // 28 MHz system clock
  input logic                        pll_locked, // async reset, active low
  input logic                        chip_req,   // chip request
  input logic                        chip_ack,   // chip acknowledge
  input logic                        cpu_req,    // cpu request
  input logic                        cpu_ack,    // cpu acknowledge
  input logic                        chip_grant, // sequencer grants
  input logic                        cpu_grant,
  input minimig_mem_pkg::seq_state_t seq_state   // sequencer state
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [3:0] chip_wait; // cycles chip req has seen no ack

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      chip_wait <= '0;
    end else if (chip_req && !chip_ack) begin
      chip_wait <= chip_wait + 4'd1;
    end else begin
      chip_wait <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  chip_ack_has_req: assert property (@(posedge clk_28) disable iff (!pll_locked)
    $rose(chip_ack) |-> $past(chip_req)) else $error("chip ack rose without req");
  cpu_ack_has_req: assert property (@(posedge clk_28) disable iff (!pll_locked)
    $rose(cpu_ack) |-> $past(cpu_req)) else $error("cpu ack rose without req");
  chip_ack_held: assert property (@(posedge clk_28) disable iff (!pll_locked)
    chip_ack && chip_req |=> chip_ack) else $error("chip ack fell while req high");
  cpu_ack_held: assert property (@(posedge clk_28) disable iff (!pll_locked)
    cpu_ack && cpu_req |=> cpu_ack) else $error("cpu ack fell while req high");
  chip_latency: assert property (@(posedge clk_28) disable iff (!pll_locked)
    chip_wait < 4'd12) else $error("chip ack later than 12 cycles");

  ////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////

  one_grant: assert property (@(posedge clk_28) disable iff (!pll_locked)
    !(chip_grant && cpu_grant)) else $error("both ports granted");
  ack_after_capture: assert property (@(posedge clk_28) disable iff (!pll_locked)
    ($rose(chip_ack) || $rose(cpu_ack)) |-> $past(seq_state) == minimig_mem_pkg::seq_capture)
    else $error("ack rose without a capture cycle before it");

endmodule

bind minimig_mem_top mem_checker hs_checks (
  .clk_28     (clk_28               ),
  .pll_locked (pll_locked           ),
  .chip_req   (chip_req             ),
  .chip_ack   (chip_ack             ),
  .cpu_req    (cpu_req              ),
  .cpu_ack    (cpu_ack              ),
  .chip_grant (chip_grant           ),
  .cpu_grant  (cpu_grant            ),
  .seq_state  (ram_sequencer.state  )
);

//--- tb_minimig_mem.sv
// testbench for the chip memory slice, random stimulus from a fixed LFSR seed
// inputs change 1 ns after the rising edge, outputs are sampled at the same point
// a word model tracks every write at its ack, reads compare against it
// RAM words are written before they are read, contents have no reset

module tb_minimig_mem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_RAND = 16; // cpu write/read pairs, test 2
  localparam int N_MIX  = 24; // transactions per port, test 4
  localparam int N_TXN  = 2 * N_RAND + 4 + 8 + 2 * N_MIX + 6;
  localparam int WATCHDOG_NS = (N_TXN * 12 * 2 + 200) * 4; // 12 cycles each, twice, 4 ns clock

  logic clk_28, pll_locked;
  logic chip_req, chip_we, chip_ack, cpu_req, cpu_we, cpu_ack;
  minimig_mem_pkg::addr_t chip_addr, cpu_addr;
  minimig_mem_pkg::word_t chip_wdata, chip_rdata, cpu_wdata, cpu_rdata;
  minimig_mem_pkg::be_t   chip_be, cpu_be;

  minimig_mem_pkg::word_t model [minimig_mem_pkg::RAM_WORDS]; // reference RAM
  minimig_mem_pkg::addr_t rand_addr [N_RAND];
  logic [21:0] chip_ops [N_MIX]; // {we, addr[2:0], be, wdata}, bits 20:18 addr
  logic [21:0] cpu_ops  [N_MIX];
  logic [31:0] lfsr;
  int errors, checks, tests_run, tests_failed, err_mark, chip_acks, cpu_acks;

  minimig_mem_top uut (.*); // port names match one to one

  always #2 clk_28 = ~clk_28; // 4 ns period

  ////////////////////////////////////////////////////////////
  // random bits and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic finish_txn(input string port, input logic we, input minimig_mem_pkg::addr_t addr,
                            input minimig_mem_pkg::word_t wdata, input minimig_mem_pkg::be_t be,
                            input minimig_mem_pkg::word_t old_rdata,
                            input minimig_mem_pkg::word_t rdata);
    checks++;
    if (we) begin
      if (be[0]) model[addr][7:0]  = wdata[7:0];  // lower byte
      if (be[1]) model[addr][15:8] = wdata[15:8]; // upper byte
      if (rdata !== old_rdata) begin
        $display("Fail %0t: %s write at %h changed rdata to %h", $time, port, addr, rdata);
        errors++;
      end
    end else if (rdata !== model[addr]) begin
      $display("Fail %0t: %s read at %h returned %h, expected %h",
               $time, port, addr, rdata, model[addr]);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // handshake drivers, called at edge + 1 ns
  ////////////////////////////////////////////////////////////

  task automatic chip_access(input logic we, input minimig_mem_pkg::addr_t addr,
                             input minimig_mem_pkg::word_t wdata, input minimig_mem_pkg::be_t be);
    minimig_mem_pkg::word_t old_rdata;
    int waited;
    old_rdata  = chip_rdata;
    waited     = 0;
    chip_we    = we;
    chip_addr  = addr;
    chip_wdata = wdata;
    chip_be    = be;
    chip_req   = 1'b1;
    do begin
      @(posedge clk_28);
      #1;
      waited++;
    end while (!chip_ack && waited < 64);
    if (!chip_ack) begin
      $display("chip port got no ack within 64 cycles at %0t", $time);
      errors++;
    end else begin
      chip_acks++;
      finish_txn("chip", we, addr, wdata, be, old_rdata, chip_rdata);
    end
    chip_req = 1'b0; // return to zero
    do begin
      @(posedge clk_28);
      #1;
    end while (chip_ack);
  endtask

  task automatic cpu_access(input logic we, input minimig_mem_pkg::addr_t addr,
                            input minimig_mem_pkg::word_t wdata, input minimig_mem_pkg::be_t be);
    minimig_mem_pkg::word_t old_rdata;
    int waited;
    old_rdata = cpu_rdata;
    waited    = 0;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_be    = be;
    cpu_req   = 1'b1;
    do begin
      @(posedge clk_28);
      #1;
      waited++;
    end while (!cpu_ack && waited < 64);
    if (!cpu_ack) begin
      $display("cpu port got no ack within 64 cycles at %0t", $time);
      errors++;
    end else begin
      cpu_acks++;
      finish_txn("cpu", we, addr, wdata, be, old_rdata, cpu_rdata);
    end
    cpu_req = 1'b0;
    do begin
      @(posedge clk_28);
      #1;
    end while (cpu_ack);
  endtask

  task automatic acks_low_for(input int cycles);
    repeat (cycles) begin
      @(posedge clk_28);
      #1;
      checks++;
      if (chip_ack !== 1'b0 || cpu_ack !== 1'b0) begin
        $display("Fail %0t: ack high while pll_locked is low", $time);
        errors++;
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    minimig_mem_pkg::addr_t a;
    int waited;
    clk_28 = 1'b0;
    pll_locked = 1'b0;
    {chip_req, chip_we, chip_addr, chip_wdata, chip_be} = '0;
    {cpu_req, cpu_we, cpu_addr, cpu_wdata, cpu_be} = '0;
    lfsr = 32'hd0cc;
    {errors, checks, tests_run, tests_failed, err_mark, chip_acks, cpu_acks} = '0;

    acks_low_for(4); // test 1, held in reset
    pll_locked = 1'b1;
    end_test("acks low in reset");

    for (int i = 0; i < N_RAND; i++) begin
      rand_addr[i] = minimig_mem_pkg::addr_t'(rand_bits(12));
      cpu_access(1'b1, rand_addr[i], minimig_mem_pkg::word_t'(rand_bits(16)), 2'b11);
    end
    for (int i = 0; i < N_RAND; i++) cpu_access(1'b0, rand_addr[i], '0, 2'b11);
    end_test("cpu write then read back");

    a = minimig_mem_pkg::addr_t'(rand_bits(12));
    chip_access(1'b1, a, minimig_mem_pkg::word_t'(rand_bits(16)), 2'b11);
    chip_access(1'b1, a, minimig_mem_pkg::word_t'(rand_bits(16)), 2'b01); // low byte only
    chip_access(1'b1, a, minimig_mem_pkg::word_t'(rand_bits(16)), 2'b10); // high byte only
    chip_access(1'b0, a, '0, 2'b11);
    end_test("chip byte enable merge");

    for (int i = 0; i < 8; i++) begin // fill shared range 0x100..0x107
      chip_access(1'b1, {9'h020, 3'(i)}, minimig_mem_pkg::word_t'(rand_bits(16)), 2'b11);
    end
    for (int i = 0; i < N_MIX; i++) begin
      chip_ops[i] = 22'(rand_bits(22));
      cpu_ops[i]  = 22'(rand_bits(22));
    end
    {chip_acks, cpu_acks} = '0;
    fork
      for (int i = 0; i < N_MIX; i++) begin
        chip_access(chip_ops[i][21], {9'h020, chip_ops[i][20:18]}, chip_ops[i][15:0],
                    chip_ops[i][17:16]);
      end
      for (int i = 0; i < N_MIX; i++) begin
        cpu_access(cpu_ops[i][21], {9'h020, cpu_ops[i][20:18]}, cpu_ops[i][15:0],
                   cpu_ops[i][17:16]);
      end
    join
    checks++;
    if (chip_acks != N_MIX || cpu_acks != N_MIX) begin
      $display("Fail %0t: acks chip %0d cpu %0d, expected %0d each",
               $time, chip_acks, cpu_acks, N_MIX);
      errors++;
    end
    end_test("interleaved chip and cpu traffic");

    cpu_we    = 1'b0; // both reads held under back-pressure
    cpu_addr  = rand_addr[0];
    cpu_req   = 1'b1;
    chip_we   = 1'b0;
    chip_addr = 12'h100;
    chip_req  = 1'b1;
    waited    = 0;
    do begin
      @(posedge clk_28);
      #1;
      waited++;
    end while (!(chip_ack && cpu_ack) && waited < 64);
    if (!(chip_ack && cpu_ack)) begin
      $display("acks did not both rise before the reset at %0t", $time);
      errors++;
    end else begin
      finish_txn("chip", 1'b0, 12'h100, '0, 2'b11, chip_rdata, chip_rdata);
      finish_txn("cpu", 1'b0, rand_addr[0], '0, 2'b11, cpu_rdata, cpu_rdata);
    end
    pll_locked = 1'b0; // lock lost with both acks high
    acks_low_for(4);
    chip_req   = 1'b0;
    cpu_req    = 1'b0;
    pll_locked = 1'b1;
    cpu_access(1'b0, rand_addr[0], '0, 2'b11); // contents kept over reset
    chip_access(1'b0, 12'h100, '0, 2'b11);
    a = minimig_mem_pkg::addr_t'(rand_bits(12));
    chip_access(1'b1, a, minimig_mem_pkg::word_t'(rand_bits(16)), 2'b11);
    cpu_access(1'b0, a, '0, 2'b11);
    end_test("reset mid-run");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
minimig_mem_pkg.sv
slot_timer.sv
ram_sequencer.sv
bus_port.sv
ram_array.sv
minimig_mem_top.sv
mem_checker.sv
tb_minimig_mem.sv

//--- Makefile
TOP := tb_minimig_mem
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module minimig_mem_top minimig_mem_pkg.sv \
	  slot_timer.sv ram_sequencer.sv bus_port.sv ram_array.sv minimig_mem_top.sv

obj_dir/V$(TOP): vlog.f *.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; echo "exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "exit status 0" $(LOG); then echo "simulation aborted"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
